// ==== src/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5
`define REG_COUNT      32

// instruction fields
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB     25
`define RS_LSB     21
`define RT_MSB     20
`define RT_LSB     16
`define RD_MSB     15
`define RD_LSB     11
`define SHAMT_MSB  10
`define SHAMT_LSB  6
`define FUNC_MSB   5
`define FUNC_LSB   0
`define IMM_MSB    15
`define IMM_LSB    0

`endif

// ==== src/mipsPkg.sv ====
package mipsPkg;

    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'b000000,
        OP_SPECIAL2 = 6'b011100,
        OP_ADDI     = 6'b001000,
        OP_ORI      = 6'b001101,
        OP_LUI      = 6'b001111
    } opcodeE;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_MFHI = 6'b010000,
        FN_MTHI = 6'b010001,
        FN_MFLO = 6'b010010,
        FN_MTLO = 6'b010011,
        FN_MULT = 6'b011000,
        FN_DIV  = 6'b011010,
        FN_ADD  = 6'b100000,
        FN_SUB  = 6'b100010
    } funcE;

    typedef enum logic [5:0] {
        FN2_MADD = 6'b000000,
        FN2_MSUB = 6'b000100
    } func2E;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV, ALU_SLL, ALU_OR, ALU_LUI
    } aluOpE;

    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_HI, WB_LO
    } wbSelE; // source for the general register

    typedef enum logic [2:0] {
        HL_NONE, HL_PRODUCT, HL_MOVE_HI, HL_MOVE_LO, HL_ACCUM_ADD, HL_ACCUM_SUB
    } hiLoOpE;

    typedef enum logic [1:0] {
        DEC_IDLE, DEC_BUSY, DEC_ACK
    } decStateE;

endpackage

// ==== src/stageIf.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

interface decodeExecIf;
    import mipsPkg::*;

    logic                       valid; // one-cycle pulse
    aluOpE                      aluOp;
    logic [`DATA_WIDTH-1:0]     opA;
    logic [`DATA_WIDTH-1:0]     opB;
    logic [`DATA_WIDTH-1:0]     rsValue;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
    wbSelE                      wbSel;
    hiLoOpE                     hiLoOp;

    modport producer (output valid, aluOp, opA, opB, rsValue, destReg, wbSel, hiLoOp);
    modport consumer (input valid, aluOp, opA, opB, rsValue, destReg, wbSel, hiLoOp);
endinterface

interface execResultIf;
    import mipsPkg::*;

    logic                       valid; // one-cycle pulse
    logic [`DATA_WIDTH-1:0]     aluLow;
    logic [`DATA_WIDTH-1:0]     aluHigh;
    logic [`DATA_WIDTH-1:0]     rsValue;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
    wbSelE                      wbSel;
    hiLoOpE                     hiLoOp;

    modport producer (output valid, aluLow, aluHigh, rsValue, destReg, wbSel, hiLoOp);
    modport consumer (input valid, aluLow, aluHigh, rsValue, destReg, wbSel, hiLoOp);
endinterface

// ==== src/instrDecode.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module instrDecode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instrReq,
    input  logic [`DATA_WIDTH-1:0]     instr,
    output logic                       instrAck,
    input  logic                       retire,
    output logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    output logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    input  logic [`DATA_WIDTH-1:0]     rsData,
    input  logic [`DATA_WIDTH-1:0]     rtData,
    decodeExecIf.producer              decExec
);
    import mipsPkg::*;

    localparam int immWidth = `IMM_MSB - `IMM_LSB + 1;
    localparam int shamtWidth = `SHAMT_MSB - `SHAMT_LSB + 1;

    decStateE                   state;
    opcodeE                     opcode;
    funcE                       func;
    func2E                      func2;
    logic [immWidth-1:0]        imm;
    logic [`DATA_WIDTH-1:0]     sextImm;
    logic [`DATA_WIDTH-1:0]     zextImm;
    logic [`DATA_WIDTH-1:0]     shamtVal;
    aluOpE                      aluOpNext;
    logic [`DATA_WIDTH-1:0]     opANext;
    logic [`DATA_WIDTH-1:0]     opBNext;
    logic [`REG_ADDR_WIDTH-1:0] destNext;
    wbSelE                      wbSelNext;
    hiLoOpE                     hiLoOpNext;
    logic                       accept;

    assign opcode = opcodeE'(instr[`OPCODE_MSB:`OPCODE_LSB]);
    assign func = funcE'(instr[`FUNC_MSB:`FUNC_LSB]);
    assign func2 = func2E'(instr[`FUNC_MSB:`FUNC_LSB]);
    assign imm = instr[`IMM_MSB:`IMM_LSB];
    assign sextImm = {{(`DATA_WIDTH - immWidth){imm[immWidth-1]}}, imm};
    assign zextImm = {{(`DATA_WIDTH - immWidth){1'b0}}, imm};
    assign shamtVal = {{(`DATA_WIDTH - shamtWidth){1'b0}}, instr[`SHAMT_MSB:`SHAMT_LSB]};
    assign rsAddr = instr[`RS_MSB:`RS_LSB];
    assign rtAddr = instr[`RT_MSB:`RT_LSB];
    assign accept = (state == DEC_IDLE) && instrReq;

    always_comb
    begin
        aluOpNext = ALU_ADD;
        opANext = rsData;
        opBNext = rtData;
        destNext = instr[`RD_MSB:`RD_LSB];
        wbSelNext = WB_NONE; // unknown codes retire as no-op
        hiLoOpNext = HL_NONE;
        case (opcode)
            OP_SPECIAL:
                case (func)
                    FN_ADD:  wbSelNext = WB_ALU;
                    FN_SUB:
                    begin
                        aluOpNext = ALU_SUB;
                        wbSelNext = WB_ALU;
                    end
                    FN_SLL:
                    begin
                        aluOpNext = ALU_SLL;
                        opANext = shamtVal;
                        wbSelNext = WB_ALU;
                    end
                    FN_MULT:
                    begin
                        aluOpNext = ALU_MUL;
                        hiLoOpNext = HL_PRODUCT;
                    end
                    FN_DIV:
                    begin
                        aluOpNext = ALU_DIV;
                        hiLoOpNext = HL_PRODUCT;
                    end
                    FN_MFHI: wbSelNext = WB_HI;
                    FN_MFLO: wbSelNext = WB_LO;
                    FN_MTHI: hiLoOpNext = HL_MOVE_HI;
                    FN_MTLO: hiLoOpNext = HL_MOVE_LO;
                    default: ;
                endcase
            OP_SPECIAL2:
            begin
                aluOpNext = ALU_MUL;
                if (func2 == FN2_MADD)
                    hiLoOpNext = HL_ACCUM_ADD;
                else if (func2 == FN2_MSUB)
                    hiLoOpNext = HL_ACCUM_SUB;
            end
            OP_ADDI:
            begin
                opBNext = sextImm;
                destNext = rtAddr;
                wbSelNext = WB_ALU;
            end
            OP_ORI, OP_LUI:
            begin
                aluOpNext = (opcode == OP_ORI) ? ALU_OR : ALU_LUI;
                opBNext = zextImm;
                destNext = rtAddr;
                wbSelNext = WB_ALU;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= DEC_IDLE;
            instrAck <= 1'b0;
            decExec.valid <= 1'b0;
        end
        else
        begin
            decExec.valid <= accept;
            case (state)
                DEC_IDLE: if (instrReq) state <= DEC_BUSY;
                DEC_BUSY:
                    if (retire)
                    begin
                        state <= DEC_ACK;
                        instrAck <= 1'b1;
                    end
                DEC_ACK:
                    if (!instrReq) // requester dropped, close the handshake
                    begin
                        state <= DEC_IDLE;
                        instrAck <= 1'b0;
                    end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            decExec.aluOp <= aluOpNext;
            decExec.opA <= opANext;
            decExec.opB <= opBNext;
            decExec.rsValue <= rsData;
            decExec.destReg <= destNext;
            decExec.wbSel <= wbSelNext;
            decExec.hiLoOp <= hiLoOpNext;
        end
    end

    ackNotIdle: assert property (@(posedge clk) disable iff (reset)
        state == DEC_IDLE |-> !instrAck);

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module regFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    input  logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    output logic [`DATA_WIDTH-1:0]     rsData,
    output logic [`DATA_WIDTH-1:0]     rtData,
    input  logic                       wrEn,
    input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
    input  logic [`DATA_WIDTH-1:0]     wrData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            regs <= '{default: '0};
        end
        else if (wrEn)
        begin
            regs[wrAddr] <= wrData; // r0 is an ordinary register here
        end
    end

    // asynchronous read ports
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

// ==== src/aluExecute.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module aluExecute (
    input  logic           clk,
    input  logic           reset,
    decodeExecIf.consumer  decExec,
    execResultIf.producer  execRes
);
    import mipsPkg::*;

    localparam int immWidth = `IMM_MSB - `IMM_LSB + 1;

    logic [2*`DATA_WIDTH-1:0] product;
    logic [`DATA_WIDTH-1:0]   lowRes;
    logic [`DATA_WIDTH-1:0]   highRes;

    assign product = {{`DATA_WIDTH{1'b0}}, decExec.opA} * {{`DATA_WIDTH{1'b0}}, decExec.opB};

    always_comb
    begin
        lowRes = '0;
        highRes = '0;
        case (decExec.aluOp)
            ALU_ADD: lowRes = decExec.opA + decExec.opB;
            ALU_SUB: lowRes = decExec.opA - decExec.opB;
            ALU_MUL: {highRes, lowRes} = product;
            ALU_DIV:
                if (decExec.opB == '0)
                begin
                    lowRes = '1; // divide by zero
                    highRes = decExec.opA;
                end
                else
                begin
                    lowRes = decExec.opA / decExec.opB;
                    highRes = decExec.opA % decExec.opB;
                end
            ALU_SLL: lowRes = decExec.opB << decExec.opA;
            ALU_OR:  lowRes = decExec.opA | decExec.opB;
            ALU_LUI:
                lowRes = {decExec.opB[immWidth-1:0], {(`DATA_WIDTH - immWidth){1'b0}}};
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            execRes.valid <= 1'b0;
        else
            execRes.valid <= decExec.valid;
    end

    always_ff @(posedge clk)
    begin
        if (decExec.valid)
        begin
            execRes.aluLow <= lowRes;
            execRes.aluHigh <= highRes;
            execRes.rsValue <= decExec.rsValue;
            execRes.destReg <= decExec.destReg;
            execRes.wbSel <= decExec.wbSel;
            execRes.hiLoOp <= decExec.hiLoOp;
        end
    end

    // a single decode pulse gives a single result pulse
    validFollows: assert property (@(posedge clk) disable iff (reset)
        decExec.valid |=> execRes.valid ##1 !execRes.valid);

endmodule

// ==== src/hiLoResult.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module hiLoResult (
    input  logic                       clk,
    input  logic                       reset,
    execResultIf.consumer              execRes,
    output logic                       wrEn,
    output logic [`REG_ADDR_WIDTH-1:0] wrAddr,
    output logic [`DATA_WIDTH-1:0]     wrData,
    output logic                       retire,
    output logic                       wbValid,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0]     wbData
);
    import mipsPkg::*;

    logic [`DATA_WIDTH-1:0]   hi;
    logic [`DATA_WIDTH-1:0]   lo;
    logic [2*`DATA_WIDTH-1:0] product;
    logic [2*`DATA_WIDTH-1:0] accum;

    assign product = {execRes.aluHigh, execRes.aluLow};
    assign accum = {hi, lo};

    assign wrEn = execRes.valid && (execRes.wbSel != WB_NONE);
    assign wrAddr = execRes.destReg;

    always_comb
    begin
        case (execRes.wbSel)
            WB_HI:   wrData = hi; // old value, update lands at the same edge
            WB_LO:   wrData = lo;
            default: wrData = execRes.aluLow;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (execRes.valid)
        begin
            case (execRes.hiLoOp)
                HL_PRODUCT:   {hi, lo} <= product;
                HL_MOVE_HI:   hi <= execRes.rsValue;
                HL_MOVE_LO:   lo <= execRes.rsValue;
                HL_ACCUM_ADD: {hi, lo} <= accum + product; // wraps at 64 bits
                HL_ACCUM_SUB: {hi, lo} <= accum - product;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            retire <= 1'b0;
            wbValid <= 1'b0;
        end
        else
        begin
            retire <= execRes.valid;
            wbValid <= wrEn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            wbReg <= wrAddr;
            wbData <= wrData;
        end
    end

    wbWithRetire: assert property (@(posedge clk) disable iff (reset)
        wbValid |-> retire);

endmodule

// ==== src/mipsCore.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module mipsCore (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instrReq,
    input  logic [`DATA_WIDTH-1:0]     instr,
    output logic                       instrAck,
    output logic                       wbValid,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0]     wbData
);

    logic [`REG_ADDR_WIDTH-1:0] rsAddr;
    logic [`REG_ADDR_WIDTH-1:0] rtAddr;
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rtData;
    logic                       wrEn;
    logic [`REG_ADDR_WIDTH-1:0] wrAddr;
    logic [`DATA_WIDTH-1:0]     wrData;
    logic                       retire;

    decodeExecIf decExecBus ();
    execResultIf execResBus ();

    instrDecode uDecode (
        .clk      (clk),
        .reset    (reset),
        .instrReq (instrReq),
        .instr    (instr),
        .instrAck (instrAck),
        .retire   (retire),
        .rsAddr   (rsAddr),
        .rtAddr   (rtAddr),
        .rsData   (rsData),
        .rtData   (rtData),
        .decExec  (decExecBus.producer)
    );

    regFile uRegFile (
        .clk    (clk),
        .reset  (reset),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    aluExecute uExecute (
        .clk     (clk),
        .reset   (reset),
        .decExec (decExecBus.consumer),
        .execRes (execResBus.producer)
    );

    hiLoResult uResult (
        .clk     (clk),
        .reset   (reset),
        .execRes (execResBus.consumer),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .retire  (retire),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

endmodule

// ==== verif/mipsCoreTb.sv ====
`timescale 1ns/1ns

module mipsCoreTb;

    localparam logic [5:0] opSpecial  = 6'h00;
    localparam logic [5:0] opSpecial2 = 6'h1c;
    localparam logic [5:0] opAddi     = 6'h08;
    localparam logic [5:0] opOri      = 6'h0d;
    localparam logic [5:0] opLui      = 6'h0f;
    localparam logic [5:0] fnSll      = 6'h00;
    localparam logic [5:0] fnMfhi     = 6'h10;
    localparam logic [5:0] fnMthi     = 6'h11;
    localparam logic [5:0] fnMflo     = 6'h12;
    localparam logic [5:0] fnMtlo     = 6'h13;
    localparam logic [5:0] fnMult     = 6'h18;
    localparam logic [5:0] fnDiv      = 6'h1a;
    localparam logic [5:0] fnAdd      = 6'h20;
    localparam logic [5:0] fnSub      = 6'h22;
    localparam logic [5:0] fnMadd     = 6'h00;
    localparam logic [5:0] fnMsub     = 6'h04;

    localparam int numRandom = 300;
    localparam int numLoads = 8;
    localparam int numArith = 60;
    localparam int numMulDiv = 20;
    localparam int numMac = 10;
    localparam int macSteps = 4;
    localparam int numUnknown = 10;
    localparam int totalInstr = numRandom + numLoads + numArith + numMulDiv * 7
        + numMac * (6 + macSteps * 5 + 2) + numUnknown * 4;
    localparam int cycleLimit = totalInstr * 8 + 100;
    localparam int ackWait = 20; // per instruction

    logic        clk;
    logic        reset;
    logic        instrReq;
    logic [31:0] instr;
    logic        instrAck;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    logic [31:0] modelRegs [32];
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    int          errors;
    int          testCount;
    int          instrCount;
    int          cycleCount;

    mipsCore dut (
        .clk      (clk),
        .reset    (reset),
        .instrReq (instrReq),
        .instr    (instr),
        .instrAck (instrAck),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles, the core stopped answering", cycleCount);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] rType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh, input logic [5:0] fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] randomInstr(input int maxKind);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        rs = 5'($urandom);
        rt = 5'($urandom);
        rd = 5'($urandom);
        imm = 16'($urandom);
        case ($urandom_range(maxKind))
            0:  return rType(opSpecial, rs, rt, rd, 5'd0, fnAdd);
            1:  return rType(opSpecial, rs, rt, rd, 5'd0, fnSub);
            2:  return rType(opSpecial, 5'd0, rt, rd, 5'($urandom), fnSll);
            3:  return iType(opAddi, rs, rt, imm);
            4:  return iType(opOri, rs, rt, imm);
            5:  return iType(opLui, 5'd0, rt, imm);
            6:  return rType(opSpecial, rs, rt, 5'd0, 5'd0, fnMult);
            7:  return rType(opSpecial, rs, rt, 5'd0, 5'd0, fnDiv);
            8:  return rType(opSpecial, 5'd0, 5'd0, rd, 5'd0, fnMfhi);
            9:  return rType(opSpecial, 5'd0, 5'd0, rd, 5'd0, fnMflo);
            10: return rType(opSpecial, rs, 5'd0, 5'd0, 5'd0, fnMthi);
            11: return rType(opSpecial, rs, 5'd0, 5'd0, 5'd0, fnMtlo);
            12: return rType(opSpecial2, rs, rt, 5'd0, 5'd0, fnMadd);
            default: return rType(opSpecial2, rs, rt, 5'd0, 5'd0, fnMsub);
        endcase
    endfunction

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("** Error at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        errors++;
    endtask

    task automatic reportFail(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    // reference model, returns the expected writeback
    task automatic modelStep(input logic [31:0] ins, output logic expValid,
                             output logic [4:0] expReg, output logic [31:0] expData);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] prod;
        logic [32:0] wb; // write flag and value
        op = ins[31:26];
        fn = ins[5:0];
        imm = ins[15:0];
        a = modelRegs[ins[25:21]];
        b = modelRegs[ins[20:16]];
        prod = {32'd0, a} * {32'd0, b};
        wb = '0;
        case (op)
            opSpecial:
                case (fn)
                    fnAdd:  wb = {1'b1, a + b};
                    fnSub:  wb = {1'b1, a - b};
                    fnSll:  wb = {1'b1, b << ins[10:6]};
                    fnMfhi: wb = {1'b1, modelHi};
                    fnMflo: wb = {1'b1, modelLo};
                    fnMthi: modelHi = a;
                    fnMtlo: modelLo = a;
                    fnMult: {modelHi, modelLo} = prod;
                    fnDiv:  {modelHi, modelLo} = (b == 0) ? {a, 32'hffff_ffff} : {a % b, a / b};
                    default: ;
                endcase
            opSpecial2:
                if (fn == fnMadd)
                    {modelHi, modelLo} = {modelHi, modelLo} + prod;
                else if (fn == fnMsub)
                    {modelHi, modelLo} = {modelHi, modelLo} - prod;
            opAddi: wb = {1'b1, a + {{16{imm[15]}}, imm}};
            opOri:  wb = {1'b1, a | {16'd0, imm}};
            opLui:  wb = {1'b1, imm, 16'd0};
            default: ; // unknown code, no effect
        endcase
        expValid = wb[32];
        expReg = (op == opSpecial) ? ins[15:11] : ins[20:16];
        expData = wb[31:0];
        if (expValid)
            modelRegs[expReg] = expData;
    endtask

    // one full four-phase transfer, called 1 ns after a rising edge
    task automatic runInstr(input logic [31:0] ins);
        logic        expValid;
        logic [4:0]  expReg;
        logic [31:0] expData;
        logic [4:0]  gotReg;
        logic [31:0] gotData;
        int          cyc;
        int          pulses;
        int          extra;
        modelStep(ins, expValid, expReg, expData);
        extra = $urandom_range(3);
        instr = ins;
        instrReq = 1'b1;
        cyc = 0;
        pulses = 0;
        gotReg = '0;
        gotData = '0;
        while (!instrAck && cyc < ackWait)
        begin
            @(posedge clk);
            #1;
            cyc++;
            if (wbValid)
            begin
                pulses++;
                gotReg = wbReg;
                gotData = wbData;
            end
        end
        if (!instrAck)
            reportFail($sformatf("no instrAck within %0d cycles for 0x%h", ackWait, ins));
        else if (cyc != 4) // E0 plus three edges
            reportValue("instrAck delay", cyc, 4);
        if (pulses != int'(expValid))
            reportValue("wbValid pulses", pulses, expValid);
        if (expValid && pulses == 1)
        begin
            if (gotReg != expReg)
                reportValue("wbReg", gotReg, expReg);
            if (gotData != expData)
                reportValue("wbData", gotData, expData);
        end
        repeat (extra)
        begin
            @(posedge clk);
            #1;
            if (!instrAck)
                reportFail("instrAck dropped while instrReq was still high");
        end
        instrReq = 1'b0;
        @(posedge clk);
        #1;
        if (instrAck)
            reportValue("instrAck after release", instrAck, 0);
        instrCount++;
    endtask

    task automatic loadWord(input logic [4:0] r, input logic [31:0] value);
        runInstr(iType(opLui, 5'd0, r, value[31:16]));
        runInstr(iType(opOri, r, r, value[15:0]));
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testCount++;
        if (errors == errBefore)
            $display("test %0d %s: ok", testCount, name);
        else
            $display("test %0d %s: %0d errors", testCount, name, errors - errBefore);
    endtask

    initial
    begin
        int          errBefore;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] ins;
        logic [31:0] value;
        void'($urandom(32'h8996_6c89));
        reset = 1'b1;
        instrReq = 1'b0;
        instr = '0;
        errors = 0;
        testCount = 0;
        instrCount = 0;
        modelRegs = '{default: '0};
        modelHi = '0;
        modelLo = '0;

        errBefore = errors;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        if (instrAck !== 1'b0)
            reportValue("instrAck", instrAck, 0);
        if (wbValid !== 1'b0)
            reportValue("wbValid", wbValid, 0);
        repeat (numRandom) runInstr(randomInstr(13));
        finishTest("handshake", errBefore);

        errBefore = errors;
        for (int i = 0; i < numLoads; i++)
            runInstr(iType(opAddi, 5'($urandom), 5'($urandom), 16'($urandom)));
        repeat (numArith) runInstr(randomInstr(5)); // add..lui only
        finishTest("arithmetic", errBefore);

        errBefore = errors;
        for (int i = 0; i < numMulDiv; i++)
        begin
            ra = 5'($urandom);
            rb = ra + 5'd1 + 5'($urandom_range(30));
            value = (i % 4 == 3) ? 32'd0 : (i % 4 == 1) ? $urandom_range(1000) + 1 : $urandom;
            loadWord(ra, $urandom);
            loadWord(rb, value);
            runInstr(rType(opSpecial, ra, rb, 5'd0, 5'd0, (i % 2) ? fnDiv : fnMult));
            runInstr(rType(opSpecial, 5'd0, 5'd0, 5'($urandom), 5'd0, fnMfhi));
            runInstr(rType(opSpecial, 5'd0, 5'd0, 5'($urandom), 5'd0, fnMflo));
        end
        finishTest("mult/div", errBefore);

        errBefore = errors;
        for (int i = 0; i < numMac; i++)
        begin
            ra = 5'($urandom);
            rb = ra + 5'd1 + 5'($urandom_range(30));
            loadWord(ra, (i == 0) ? 32'hffff_ffff : $urandom); // near the top, forces a wrap
            runInstr(rType(opSpecial, ra, 5'd0, 5'd0, 5'd0, fnMthi));
            loadWord(ra, (i == 0) ? 32'hffff_fff0 : $urandom);
            runInstr(rType(opSpecial, ra, 5'd0, 5'd0, 5'd0, fnMtlo));
            for (int s = 0; s < macSteps; s++)
            begin
                loadWord(ra, $urandom);
                loadWord(rb, $urandom);
                ins = rType(opSpecial2, ra, rb, 5'd0, 5'd0,
                            (i == 0 || $urandom_range(1) == 0) ? fnMadd : fnMsub);
                runInstr(ins);
            end
            runInstr(rType(opSpecial, 5'd0, 5'd0, 5'($urandom), 5'd0, fnMfhi));
            runInstr(rType(opSpecial, 5'd0, 5'd0, 5'($urandom), 5'd0, fnMflo));
        end
        finishTest("accumulate", errBefore);

        errBefore = errors;
        for (int i = 0; i < numUnknown; i++)
        begin
            case (i % 4)
                0: ins = iType(6'h23, 5'($urandom), 5'($urandom), 16'($urandom)); // lw
                1: ins = rType(opSpecial, 5'($urandom), 5'($urandom), 5'($urandom), 5'd0, 6'h21);
                2: ins = rType(opSpecial2, 5'($urandom), 5'($urandom), 5'($urandom), 5'd0, 6'h02);
                default: ins = {6'h02, 26'($urandom)}; // j
            endcase
            ra = ins[20:16];
            rb = ins[15:11];
            runInstr(ins);
            runInstr(rType(opSpecial, ra, rb, ra, 5'd0, fnAdd)); // both fields still intact
            runInstr(rType(opSpecial, 5'd0, 5'd0, 5'($urandom), 5'd0, fnMfhi));
            runInstr(rType(opSpecial, 5'd0, 5'd0, 5'($urandom), 5'd0, fnMflo));
        end
        finishTest("unknown", errBefore);

        $display("%0d tests, %0d instructions, %0d errors", testCount, instrCount, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
src/mipsPkg.sv
src/stageIf.sv
src/instrDecode.sv
src/regFile.sv
src/aluExecute.sv
src/hiLoResult.sv
src/mipsCore.sv
verif/mipsCoreTb.sv
